// File: build.f
+incdir+verilog
+incdir+bench
verilog/ex_pkg.sv
verilog/alu_core.sv
verilog/branch_eval.sv
verilog/ex_retire_reg.sv
verilog/ex_alu_unit.sv
bench/tb_ex_alu_unit.sv

// File: Bender.yml
package:
  name: ex_alu_unit

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ex_pkg.sv
      - verilog/alu_core.sv
      - verilog/branch_eval.sv
      - verilog/ex_retire_reg.sv
      - verilog/ex_alu_unit.sv
  - target: simulation
    include_dirs:
      - verilog
      - bench
    files:
      - bench/tb_ex_alu_unit.sv

// File: bench/alu_ref_model.svh
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// Operand pair for each instruction class
function automatic void ref_operands(input ex_pkg::issue_pkt_t pkt,
                                     output logic [63:0] opa, output logic [63:0] opb);
  logic [2:0]         cls;
  logic signed [63:0] disp;
  cls = pkt.ir[31:29];
  opa = pkt.prega;
  opb = pkt.pregb;
  if (cls == 3'b010) begin
    if (pkt.ir[12]) opb = {56'd0, pkt.ir[20:13]};  // 8-bit literal
  end else if (cls == 3'b001 || cls == 3'b100 || cls == 3'b101) begin
    disp = $signed(pkt.ir[15:0]);  // Sign extends on assignment
    opa = disp;
  end else if (cls == 3'b011) begin
    opa = 64'hffff_ffff_ffff_fffc;
  end else if (cls[2:1] == 2'b11) begin
    disp = $signed(pkt.ir[20:0]);
    opa = pkt.npc;
    opb = disp * 4;  // Word displacement
  end
endfunction

function automatic logic [63:0] ref_alu(input ex_pkg::alu_func_t func,
                                        input logic [63:0] a, input logic [63:0] b);
  logic [5:0] sh;
  sh = b[5:0];  // Shift count is the low six bits
  case (func)
    ex_pkg::ALU_ADDQ:   return a + b;
    ex_pkg::ALU_SUBQ:   return a - b;
    ex_pkg::ALU_AND:    return a & b;
    ex_pkg::ALU_BIC:    return a & ~b;
    ex_pkg::ALU_BIS:    return a | b;
    ex_pkg::ALU_ORNOT:  return a | ~b;
    ex_pkg::ALU_XOR:    return a ^ b;
    ex_pkg::ALU_EQV:    return ~(a ^ b);
    ex_pkg::ALU_SRL:    return a >> sh;
    ex_pkg::ALU_SLL:    return a << sh;
    ex_pkg::ALU_SRA:    return $signed(a) >>> sh;
    ex_pkg::ALU_CMPULT: return {63'd0, a < b};
    ex_pkg::ALU_CMPULE: return {63'd0, a <= b};
    ex_pkg::ALU_CMPEQ:  return {63'd0, a == b};
    ex_pkg::ALU_CMPLT:  return {63'd0, $signed(a) < $signed(b)};
    ex_pkg::ALU_CMPLE:  return {63'd0, $signed(a) <= $signed(b)};
    default:            return 64'd0;  // Not generated
  endcase
endfunction

// Branch class and taken decision
function automatic void ref_branch(input logic [63:0] ra, input logic [31:0] ir,
                                   output logic is_br, output logic taken);
  logic cond;
  is_br = (ir[31:29] == 3'b011) || (ir[31:30] == 2'b11);
  case (ir[27:26])
    2'b00:   cond = (ra[0] == 1'b0);
    2'b01:   cond = (ra == 64'd0);
    2'b10:   cond = ($signed(ra) < 0);
    default: cond = ($signed(ra) <= 0);
  endcase
  if (ir[28]) cond = !cond;  // Inverted sense
  if (!is_br) taken = 1'b0;
  else if (ir[31:29] == 3'b011 || ir[31:26] == `BR_INST || ir[31:26] == `BSR_INST)
    taken = 1'b1;
  else taken = cond;
endfunction

`endif

// File: bench/tb_ex_alu_unit.sv
`timescale 1ns/1ps
`include "ex_params.svh"

module tb_ex_alu_unit;

  localparam int RESET_CYCLES = 4;
  localparam int N_OPERATE = 64;  // Every function twice in each operand form
  localparam int N_ADDRESS = 24;
  localparam int N_COND_BR = 64;
  localparam int N_UNCOND = 24;
  localparam int N_MIXED = 200;
  localparam int TOTAL_CYCLES = RESET_CYCLES + N_OPERATE + N_ADDRESS + N_COND_BR +
                                N_UNCOND + N_MIXED + 4;

  logic               clk;
  logic               reset;
  ex_pkg::issue_pkt_t issue;
  logic               ex_en;
  logic               next_gnt;
  logic               stall;
  ex_pkg::ex_result_t res;
  logic               done;
  logic               done_reg;
  logic               gnt_reg;

  ex_pkg::ex_result_t exp_q[$];   // Records the DUT will capture next
  string              name_q[$];
  ex_pkg::ex_result_t exp_cur;    // Record the DUT should hold now
  string              cur_name;
  logic               exp_done;
  logic               exp_gnt;
  int                 checks;
  int                 value_errors;
  int                 other_errors;

  ex_pkg::alu_func_t func_list [16] = '{
    ex_pkg::ALU_ADDQ, ex_pkg::ALU_SUBQ, ex_pkg::ALU_AND, ex_pkg::ALU_BIC,
    ex_pkg::ALU_BIS, ex_pkg::ALU_ORNOT, ex_pkg::ALU_XOR, ex_pkg::ALU_EQV,
    ex_pkg::ALU_SRL, ex_pkg::ALU_SLL, ex_pkg::ALU_SRA, ex_pkg::ALU_CMPEQ,
    ex_pkg::ALU_CMPLT, ex_pkg::ALU_CMPLE, ex_pkg::ALU_CMPULT, ex_pkg::ALU_CMPULE
  };

  `include "alu_ref_model.svh"

  ex_alu_unit i_ex_alu_unit (
    .clk      (clk),
    .reset    (reset),
    .issue    (issue),
    .ex_en    (ex_en),
    .next_gnt (next_gnt),
    .stall    (stall),
    .res      (res),
    .done     (done),
    .done_reg (done_reg),
    .gnt_reg  (gnt_reg)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;  // 100 ns period

  // Watchdog sized from the test lengths with 2x margin
  initial begin
    #(TOTAL_CYCLES * 200);
    $display("Timeout: the test sequence did not finish in time");
    $display("SOME TESTS FAILED");
    $finish;
  end

  function automatic logic [63:0] random_word();
    return {$urandom, $urandom};
  endfunction

  function automatic logic random_bit();
    logic [31:0] r;
    r = $urandom;
    return r[0];
  endfunction

  // Mix of corner values and plain random words
  function automatic logic [63:0] pick_operand();
    logic [63:0] w;
    logic [31:0] r;
    w = random_word();
    r = $urandom % 6;
    case (r)
      0: w = 64'd0;
      1: w = '1;                 // Negative and odd
      2: w[63] = 1'b1;           // Negative
      3: w = {58'd0, w[5:0]};    // Small, fits a shift count
      4: w[0] = 1'b1;            // Odd
      default: ;
    endcase
    return w;
  endfunction

  function automatic ex_pkg::issue_pkt_t make_pkt(input logic [31:0] ir,
                                                  input ex_pkg::alu_func_t func);
    ex_pkg::issue_pkt_t pkt;
    logic [31:0]        r;
    r = $urandom;
    pkt.prega = pick_operand();
    pkt.pregb = pick_operand();
    if (r[2:0] == 3'd0) pkt.pregb = pkt.prega;  // Equal operands for the compares
    pkt.alu_func = func;
    pkt.pdest_idx = r[`PRF_IDX+7:8];
    pkt.ir = ir;
    pkt.npc = random_word() & ~64'h3;
    pkt.rob_idx = r[`ROB_IDX+19:20];
    return pkt;
  endfunction

  function automatic ex_pkg::issue_pkt_t idle_pkt();
    ex_pkg::issue_pkt_t pkt;
    pkt = '0;
    pkt.alu_func = ex_pkg::ALU_BIS;
    pkt.pdest_idx = `ZERO_PRF;
    pkt.ir = `NOOP_INST;
    return pkt;
  endfunction

  function automatic logic [31:0] class_ir(input logic [2:0] cls);
    logic [31:0] ir;
    ir = $urandom;
    ir[31:29] = cls;
    return ir;
  endfunction

  function automatic logic [31:0] cond_branch_ir();
    logic [31:0] ir;
    do begin
      ir = class_ir({2'b11, random_bit()});
    end while (ir[31:26] == `BR_INST || ir[31:26] == `BSR_INST);
    return ir;
  endfunction

  // Any class from the decode table
  function automatic logic [31:0] mixed_ir();
    case ($urandom % 7)
      0: return class_ir(3'b001);
      1: return class_ir(3'b100);
      2: return class_ir(3'b101);
      3: return class_ir(3'b011);
      4: return class_ir(3'b110);
      5: return class_ir(3'b111);
      default: return class_ir(3'b010);
    endcase
  endfunction

  function automatic ex_pkg::ex_result_t expected_record(input ex_pkg::issue_pkt_t pkt);
    ex_pkg::ex_result_t r;
    logic [63:0]        opa;
    logic [63:0]        opb;
    logic [63:0]        alu;
    logic               is_br;
    logic               taken;
    ref_operands(pkt, opa, opb);
    alu = ref_alu(pkt.alu_func, opa, opb);
    ref_branch(pkt.prega, pkt.ir, is_br, taken);
    r.result = is_br ? pkt.npc : alu;  // Link value for branches
    r.br_taken = taken;
    r.br_target = is_br ? alu : 64'd0;
    r.pdest_idx = pkt.pdest_idx;
    r.ir = pkt.ir;
    r.npc = pkt.npc;
    r.rob_idx = pkt.rob_idx;
    return r;
  endfunction

  task automatic check_value(input string name, input string field,
                             input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (exp !== act) begin
      value_errors++;
      $display("Error %s %s: expected %h, actual %h", name, field, exp, act);
    end
  endtask

  task automatic check_outputs();
    check_value(cur_name, "result", exp_cur.result, res.result);
    check_value(cur_name, "br_taken", exp_cur.br_taken, res.br_taken);
    check_value(cur_name, "br_target", exp_cur.br_target, res.br_target);
    check_value(cur_name, "pdest_idx", exp_cur.pdest_idx, res.pdest_idx);
    check_value(cur_name, "ir", exp_cur.ir, res.ir);
    check_value(cur_name, "npc", exp_cur.npc, res.npc);
    check_value(cur_name, "rob_idx", exp_cur.rob_idx, res.rob_idx);
    check_value(cur_name, "done_reg", exp_done, done_reg);
    check_value(cur_name, "gnt_reg", exp_gnt, gnt_reg);
    check_value(cur_name, "done", ex_en, done);  // Same-cycle echo
  endtask

  // One clock: retire the captured inputs in the model, drive new ones, check
  task automatic run_cycle(input string name, input ex_pkg::issue_pkt_t pkt,
                           input logic en, input logic stl, input logic gnt);
    @(posedge clk);
    if (!stall) begin
      if (exp_q.size() == 0) begin
        other_errors++;
        $display("Scoreboard had no expected record for an unstalled cycle");
      end else begin
        exp_cur = exp_q.pop_front();
        cur_name = name_q.pop_front();
      end
      exp_done = ex_en;
    end
    exp_gnt = next_gnt;  // Grant ignores stall
    issue <= pkt;
    ex_en <= en;
    stall <= stl;
    next_gnt <= gnt;
    if (!stl) begin
      exp_q.push_back(expected_record(pkt));
      name_q.push_back(name);
    end
    @(negedge clk);
    check_outputs();
  endtask

  initial begin
    ex_pkg::issue_pkt_t pkt;
    logic               unc_jump;
    void'($urandom(71));
    checks = 0;
    value_errors = 0;
    other_errors = 0;
    reset <= 1'b1;
    issue <= make_pkt(class_ir(3'b010), ex_pkg::ALU_ADDQ);  // Busy inputs under reset
    ex_en <= 1'b1;
    next_gnt <= 1'b1;
    stall <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    issue <= idle_pkt();
    ex_en <= 1'b0;
    next_gnt <= 1'b0;
    @(negedge clk);
    exp_cur = '0;  // Reset record
    exp_cur.pdest_idx = `ZERO_PRF;
    exp_cur.ir = `NOOP_INST;
    exp_done = 1'b0;
    exp_gnt = 1'b0;
    cur_name = "reset";
    check_outputs();
    exp_q.push_back(expected_record(issue));  // Idle packet loads on the next edge
    name_q.push_back("idle");
    for (int i = 0; i < N_OPERATE; i++) begin
      pkt = make_pkt(class_ir(3'b010), func_list[i % 16]);
      pkt.ir[12] = ((i / 16) % 2 == 1);  // Literal form in alternate sweeps
      run_cycle("operate", pkt, 1'b1, 1'b0, random_bit());
    end
    for (int i = 0; i < N_ADDRESS; i++) begin
      pkt = make_pkt(mixed_ir(), ex_pkg::ALU_ADDQ);
      pkt.ir[31:29] = (i % 3 == 0) ? 3'b001 : (i % 3 == 1) ? 3'b100 : 3'b101;
      run_cycle("address", pkt, 1'b1, 1'b0, random_bit());
    end
    for (int i = 0; i < N_COND_BR; i++) begin
      pkt = make_pkt(cond_branch_ir(), ex_pkg::ALU_ADDQ);
      run_cycle("cond_branch", pkt, 1'b1, 1'b0, random_bit());
    end
    for (int i = 0; i < N_UNCOND; i++) begin
      unc_jump = (i % 3 == 2);
      pkt = make_pkt(class_ir(3'b011), unc_jump ? ex_pkg::ALU_AND : ex_pkg::ALU_ADDQ);
      if (!unc_jump) pkt.ir[31:26] = (i % 3 == 0) ? `BR_INST : `BSR_INST;
      run_cycle("uncond_branch", pkt, 1'b1, 1'b0, random_bit());
    end
    for (int i = 0; i < N_MIXED; i++) begin
      pkt = make_pkt(mixed_ir(), func_list[$urandom % 16]);
      run_cycle("stall_mix", pkt, ($urandom % 4 != 0), ($urandom % 3 == 0), random_bit());
    end
    run_cycle("drain", idle_pkt(), 1'b0, 1'b0, 1'b0);
    $display("Checks %0d, value errors %0d, other errors %0d",
             checks, value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: verilog/ex_alu_unit.sv
`timescale 1ns/1ps

module ex_alu_unit (
  input  logic               clk,
  input  logic               reset,
  input  ex_pkg::issue_pkt_t issue,
  input  logic               ex_en,
  input  logic               next_gnt,
  input  logic               stall,
  output ex_pkg::ex_result_t res,
  output logic               done,
  output logic               done_reg,
  output logic               gnt_reg
);

  logic [63:0]      alu_out;
  ex_pkg::br_eval_t br;

  // Request goes to the arbiter in the issue cycle
  assign done = ex_en;

  alu_core i_alu_core (
    .issue   (issue),
    .alu_out (alu_out)
  );

  // Condition is tested on ra only
  branch_eval i_branch_eval (
    .prega (issue.prega),
    .ir    (issue.ir),
    .br    (br)
  );

  ex_retire_reg i_ex_retire_reg (
    .clk      (clk),
    .reset    (reset),
    .issue    (issue),
    .alu_out  (alu_out),
    .br       (br),
    .ex_en    (ex_en),
    .stall    (stall),
    .next_gnt (next_gnt),
    .res      (res),
    .done_reg (done_reg),
    .gnt_reg  (gnt_reg)
  );

endmodule

// File: verilog/ex_retire_reg.sv
`timescale 1ns/1ps
`include "ex_params.svh"

module ex_retire_reg (
  input  logic               clk,
  input  logic               reset,
  input  ex_pkg::issue_pkt_t issue,
  input  logic [63:0]        alu_out,
  input  ex_pkg::br_eval_t   br,
  input  logic               ex_en,
  input  logic               stall,
  input  logic               next_gnt,
  output ex_pkg::ex_result_t res,
  output logic               done_reg,
  output logic               gnt_reg
);

  ex_pkg::ex_result_t res_next;

  // Branches write back the link address and send the ALU sum as target
  always_comb begin
    res_next.result    = br.is_branch ? issue.npc : alu_out;
    res_next.br_taken  = br.taken;
    res_next.br_target = br.is_branch ? alu_out : 64'd0;
    res_next.pdest_idx = issue.pdest_idx;
    res_next.ir        = issue.ir;
    res_next.npc       = issue.npc;
    res_next.rob_idx   = issue.rob_idx;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      res.result    <= 64'd0;
      res.br_taken  <= 1'b0;
      res.br_target <= 64'd0;
      res.pdest_idx <= `ZERO_PRF;  // Idle record writes nothing
      res.ir        <= `NOOP_INST;
      res.npc       <= 64'd0;
      res.rob_idx   <= '0;
      done_reg      <= 1'b0;
    end else if (!stall) begin
      res      <= res_next;
      done_reg <= ex_en;
    end
  end

  // Grant is pipelined regardless of stall
  always_ff @(posedge clk) begin
    if (reset) begin
      gnt_reg <= 1'b0;
    end else begin
      gnt_reg <= next_gnt;
    end
  end

  // A taken record must carry a branch-class instruction word
  a_taken_is_branch: assert property (
    @(posedge clk) disable iff (reset)
    res.br_taken |-> (res.ir[31:29] inside {3'b011, 3'b110, 3'b111})
  );

  // Stall freezes the whole output record
  a_stall_holds: assert property (
    @(posedge clk) disable iff (reset)
    stall |=> ($stable(res) && $stable(done_reg))
  );

endmodule

// File: verilog/branch_eval.sv
`timescale 1ns/1ps
`include "ex_params.svh"

module branch_eval (
  input  logic [63:0]      prega,
  input  logic [31:0]      ir,
  output ex_pkg::br_eval_t br
);

  logic [2:0] inst_class;
  logic       is_branch;
  logic       uncond;
  logic       cond_raw;
  logic       cond;

  assign inst_class = ir[31:29];

  // Jumps and both PC-relative groups
  assign is_branch = (inst_class == 3'b011) || (inst_class == 3'b110) ||
                     (inst_class == 3'b111);

  // Jump class and br/bsr ignore the register condition
  assign uncond = (inst_class == 3'b011) ||
                  (ir[31:26] == `BR_INST) || (ir[31:26] == `BSR_INST);

  always_comb begin
    case (ir[27:26])
      2'b00: cond_raw = ~prega[0];                   // Low bit clear
      2'b01: cond_raw = (prega == 64'd0);            // Zero
      2'b10: cond_raw = prega[63];                   // Negative
      default: cond_raw = prega[63] || (prega == 64'd0);  // Negative or zero
    endcase
  end

  assign cond = cond_raw ^ ir[28];  // Bit 28 flips the sense

  // Taken stays low for anything that is not a branch
  assign br.is_branch = is_branch;
  assign br.taken     = is_branch & (uncond | cond);

endmodule

// File: verilog/alu_core.sv
`timescale 1ns/1ps

module alu_core (
  input  ex_pkg::issue_pkt_t issue,
  output logic [63:0]        alu_out
);

  localparam logic [63:0] OPND_POISON = 64'hbaadbeefdeadbeef;  // Unknown class
  localparam logic [63:0] FUNC_POISON = 64'hdeadbeefbaadbeef;  // Unknown function

  logic [2:0]  inst_class;
  logic [63:0] opa;
  logic [63:0] opb;
  logic [5:0]  shamt;
  logic [63:0] srl_val;
  logic [63:0] sra_fill;
  logic        ult;
  logic        eq;
  logic        slt;

  assign inst_class = issue.ir[31:29];

  // Operand select by instruction class
  always_comb begin
    case (inst_class)
      3'b010: begin  // Operate, register or 8-bit literal
        opa = issue.prega;
        opb = issue.ir[12] ? {56'b0, issue.ir[20:13]} : issue.pregb;
      end
      3'b001, 3'b100, 3'b101: begin  // lda and memory forms, disp + base
        opa = {{48{issue.ir[15]}}, issue.ir[15:0]};
        opb = issue.pregb;
      end
      3'b011: begin
        opa = ~64'h3;  // Jump target, clear low two bits of rb
        opb = issue.pregb;
      end
      3'b110, 3'b111: begin  // PC-relative branches
        opa = issue.npc;
        opb = {{41{issue.ir[20]}}, issue.ir[20:0], 2'b00};
      end
      default: begin
        opa = OPND_POISON;
        opb = OPND_POISON;
      end
    endcase
  end

  assign shamt = opb[5:0];
  assign srl_val = opa >> shamt;
  // Top shamt bits set, filled with the sign
  assign sra_fill = ~(64'hffff_ffff_ffff_ffff >> shamt) & {64{opa[63]}};

  assign ult = opa < opb;
  assign eq  = opa == opb;
  // Same sign means unsigned order holds, otherwise the negative one is smaller
  assign slt = (opa[63] == opb[63]) ? ult : opa[63];

  always_comb begin
    case (issue.alu_func)
      ex_pkg::ALU_ADDQ:   alu_out = opa + opb;
      ex_pkg::ALU_SUBQ:   alu_out = opa - opb;
      ex_pkg::ALU_AND:    alu_out = opa & opb;
      ex_pkg::ALU_BIC:    alu_out = opa & ~opb;
      ex_pkg::ALU_BIS:    alu_out = opa | opb;
      ex_pkg::ALU_ORNOT:  alu_out = opa | ~opb;
      ex_pkg::ALU_XOR:    alu_out = opa ^ opb;
      ex_pkg::ALU_EQV:    alu_out = opa ^ ~opb;
      ex_pkg::ALU_SRL:    alu_out = srl_val;
      ex_pkg::ALU_SLL:    alu_out = opa << shamt;
      ex_pkg::ALU_SRA:    alu_out = srl_val | sra_fill;
      ex_pkg::ALU_CMPULT: alu_out = {63'd0, ult};
      ex_pkg::ALU_CMPULE: alu_out = {63'd0, ult | eq};
      ex_pkg::ALU_CMPEQ:  alu_out = {63'd0, eq};
      ex_pkg::ALU_CMPLT:  alu_out = {63'd0, slt};
      ex_pkg::ALU_CMPLE:  alu_out = {63'd0, slt | eq};
      default:            alu_out = FUNC_POISON;
    endcase
  end

endmodule

// File: verilog/ex_pkg.sv
`include "ex_params.svh"

package ex_pkg;

  // ALU function codes, 0x0b is the multiply slot and stays unused here
  typedef enum logic [4:0] {
    ALU_ADDQ   = 5'h00,
    ALU_SUBQ   = 5'h01,
    ALU_AND    = 5'h02,
    ALU_BIC    = 5'h03,  // and-not
    ALU_BIS    = 5'h04,  // or
    ALU_ORNOT  = 5'h05,
    ALU_XOR    = 5'h06,
    ALU_EQV    = 5'h07,  // xnor
    ALU_SRL    = 5'h08,
    ALU_SLL    = 5'h09,
    ALU_SRA    = 5'h0a,
    ALU_CMPEQ  = 5'h0c,
    ALU_CMPLT  = 5'h0d,  // signed
    ALU_CMPLE  = 5'h0e,  // signed
    ALU_CMPULT = 5'h0f,
    ALU_CMPULE = 5'h10
  } alu_func_t;

  // One issued instruction with its operand values
  typedef struct packed {
    logic [63:0]          prega;
    logic [63:0]          pregb;
    alu_func_t            alu_func;
    logic [`PRF_IDX-1:0]  pdest_idx;
    logic [31:0]          ir;
    logic [63:0]          npc;
    logic [`ROB_IDX-1:0]  rob_idx;
  } issue_pkt_t;

  // Branch decode and outcome
  typedef struct packed {
    logic is_branch;
    logic taken;  // Never set without is_branch
  } br_eval_t;

  // Registered output record of the stage
  typedef struct packed {
    logic [63:0]          result;
    logic                 br_taken;
    logic [63:0]          br_target;
    logic [`PRF_IDX-1:0]  pdest_idx;
    logic [31:0]          ir;
    logic [63:0]          npc;
    logic [`ROB_IDX-1:0]  rob_idx;
  } ex_result_t;

endpackage

// File: verilog/ex_params.svh
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// Physical register tag width
`define PRF_IDX 6

// Reorder buffer tag width
`define ROB_IDX 5

// Architectural zero register, also the idle destination tag
`define ZERO_PRF 6'd31

// Alpha no-op: bis r31,r31,r31
`define NOOP_INST 32'h47ff041f

// Major opcodes of the PC-relative unconditional branches
`define BR_INST 6'h30   // br
`define BSR_INST 6'h34  // bsr

`endif
